// File: src/buf_ctrl_pkg.sv
//////////////////////////////
// buffer control types
// rotation phase of the three banks and
// the input buffer state
//////////////////////////////

package buf_ctrl_pkg;

   // which bank the input stream owns
   typedef enum logic [1:0] {
      PHASE_0 = 2'd0,
      PHASE_1 = 2'd1,
      PHASE_2 = 2'd2
   } tribuf_phase_t;

   // also driven out as input_buffer_status
   typedef enum logic [1:0] {
      IBUF_IDLE   = 2'd0,
      IBUF_STREAM = 2'd1,
      IBUF_FULL   = 2'd2
   } ibuf_state_t;

endpackage

// File: src/sample_pkg.sv
//////////////////////////////
// sample format
// width of a block floating-point
// bit-width count
//////////////////////////////

package sample_pkg;

   // enough for samples up to 32 bits
   parameter int BFP_W = 6;

   // unsigned count of significant bits
   typedef logic [BFP_W-1:0] sample_bw_t;

endpackage

// File: src/sample_bank.sv
//////////////////////////////
// half-buffer RAM
// synchronous write, read data
// registered on ract
//////////////////////////////

module sample_bank #(
   parameter int DEPTH = 8,
   parameter int DW = 16,
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
   input  logic          clk,
   input  logic          wact,
   input  logic [AW-1:0] wa,
   input  logic [2*DW-1:0] wdw,
   input  logic          ract,
   input  logic [AW-1:0] ra,
   output logic [2*DW-1:0] rdr
);

   // {imag, real} per word
   logic [2*DW-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wact) begin
         mem[wa] <= wdw;
      end
   end

   // holds last read until the next strobe
   always_ff @(posedge clk) begin
      if (ract) begin
         rdr <= mem[ra];
      end
   end

endmodule

// File: src/istream_writer.sv
//////////////////////////////
// input stream writer
// input buffer FSM and the
// bit-reversed sample address
//////////////////////////////

module istream_writer
   import buf_ctrl_pkg::*;
#(
   parameter int FRAME_LEN = 16,
   localparam int AW = $clog2(FRAME_LEN)
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          run,
   input  logic          sact_istream,
   output logic          wr_act,
   output logic [AW-1:0] wr_addr,
   output ibuf_state_t   input_buffer_status
);

   ibuf_state_t state;
   ibuf_state_t state_n;
   logic [AW-1:0] cnt;
   logic last_sample;

   assign input_buffer_status = state;

   // samples only land while streaming
   assign wr_act = sact_istream && (state == IBUF_STREAM);
   assign last_sample = (cnt == AW'(FRAME_LEN - 1));

   //////////////////////////////
   // input buffer FSM
   //////////////////////////////
   always_comb begin
      state_n = state;
      case (state)
         IBUF_IDLE: state_n = IBUF_STREAM;
         IBUF_STREAM: begin
            if (!run && wr_act && last_sample) begin
               state_n = IBUF_FULL;
            end
         end
         IBUF_FULL: begin
            if (run) begin
               state_n = IBUF_STREAM;
            end
         end
         default: state_n = IBUF_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IBUF_IDLE;
      end else begin
         state <= state_n;
      end
   end

   // sample counter, restarts the frame on run
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt <= '0;
      end else if (run || state != IBUF_STREAM) begin
         cnt <= '0;
      end else if (wr_act) begin
         cnt <= cnt + 1'b1;
      end
   end

   // reverse the count into the frame index
   always_comb begin
      for (int i = 0; i < AW; i++) begin
         wr_addr[i] = cnt[AW-1-i];
      end
   end

   // a full buffer takes no sample until the next run
   a_no_write_when_full : assert property (
      @(posedge clk) disable iff (rst)
      (state == IBUF_FULL && !run) |=> !wr_act
   );

endmodule

// File: src/bfp_frame_scale.sv
//////////////////////////////
// frame scale tracker
// bit width of each accepted sample,
// frame maximum latched on run
//////////////////////////////

module bfp_frame_scale
   import sample_pkg::*;
#(
   parameter int DW = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  logic                 sample_act,
   input  logic signed [DW-1:0] sample_real,
   input  logic signed [DW-1:0] sample_imag,
   output sample_bw_t           frame_bw
);

   sample_bw_t bw_real;
   sample_bw_t bw_imag;
   sample_bw_t sample_bw;
   sample_bw_t run_max;
   sample_bw_t run_max_n;

   // smallest two's complement width, 0 and -1 give 1
   function automatic sample_bw_t bit_width(input logic signed [DW-1:0] v);
      logic [DW-1:0] m;
      sample_bw_t n;
      m = v[DW-1] ? ~v : v;
      n = sample_bw_t'(1);
      for (int i = 0; i < DW - 1; i++) begin
         if (m[i]) begin
            n = sample_bw_t'(i + 2);
         end
      end
      return n;
   endfunction

   assign bw_real = bit_width(sample_real);
   assign bw_imag = bit_width(sample_imag);
   assign sample_bw = (bw_real > bw_imag) ? bw_real : bw_imag;

   // a sample in the run cycle still counts for the old frame
   assign run_max_n = (sample_act && sample_bw > run_max) ? sample_bw : run_max;

   always_ff @(posedge clk) begin
      if (rst) begin
         run_max <= sample_bw_t'(1);
         frame_bw <= sample_bw_t'(1);
      end else if (run) begin
         run_max <= sample_bw_t'(1);
         frame_bw <= run_max_n;
      end else begin
         run_max <= run_max_n;
      end
   end

   // never wider than a sample, never below one bit
   a_frame_bw_range : assert property (
      @(posedge clk) disable iff (rst)
      (frame_bw >= sample_bw_t'(1)) && (frame_bw <= DW)
   );

endmodule

// File: src/tribuf_arbiter.sv
//////////////////////////////
// triple buffer bank router
// rotates three banks on run, steers the
// writer and the DMA port, holds the RAMs
//////////////////////////////

module tribuf_arbiter
   import buf_ctrl_pkg::*;
#(
   parameter int FRAME_LEN = 16,
   parameter int DW = 16,
   localparam int AW = $clog2(FRAME_LEN)
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  logic                 wr_act,
   input  logic [AW-1:0]        wr_addr,
   input  logic signed [DW-1:0] wr_real,
   input  logic signed [DW-1:0] wr_imag,
   input  logic                 dmaact,
   input  logic [AW-1:0]        dmaa,
   output logic signed [DW-1:0] dmadr_real,
   output logic signed [DW-1:0] dmadr_imag
);

   tribuf_phase_t phase;
   logic [1:0] wr_bank;
   logic [1:0] dma_bank;
   logic [1:0] dma_bank_q;
   logic dma_lsb_q;
   logic dma_seen;
   logic [2*DW-1:0] wdw;
   logic [2*DW-1:0] rd_word;
   logic [2*DW-1:0] rdr [3][2];

   //////////////////////////////
   // phase rotation
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= PHASE_0;
      end else if (run) begin
         case (phase)
            PHASE_0: phase <= PHASE_1;
            PHASE_1: phase <= PHASE_2;
            default: phase <= PHASE_0;
         endcase
      end
   end

   // writer owns bank p, DMA reads p+1, p+2 is held
   assign wr_bank = 2'(phase);

   always_comb begin
      case (phase)
         PHASE_0: dma_bank = 2'd1;
         PHASE_1: dma_bank = 2'd2;
         default: dma_bank = 2'd0;
      endcase
   end

   assign wdw = {wr_imag, wr_real};

   //////////////////////////////
   // banks, even/odd by addr lsb
   //////////////////////////////
   for (genvar b = 0; b < 3; b++) begin : g_bank
      for (genvar h = 0; h < 2; h++) begin : g_half
         sample_bank #(
            .DEPTH (FRAME_LEN / 2),
            .DW    (DW)
         ) u_bank (
            .clk  (clk),
            .wact (wr_act && wr_bank == 2'(b) && wr_addr[0] == 1'(h)),
            .wa   (wr_addr[AW-1:1]),
            .wdw  (wdw),
            .ract (dmaact && dma_bank == 2'(b) && dmaa[0] == 1'(h)),
            .ra   (dmaa[AW-1:1]),
            .rdr  (rdr[b][h])
         );
      end
   end

   // remember which RAM answered the last read
   always_ff @(posedge clk) begin
      if (rst) begin
         dma_seen <= 1'b0;
         dma_bank_q <= 2'd0;
         dma_lsb_q <= 1'b0;
      end else if (dmaact) begin
         dma_seen <= 1'b1;
         dma_bank_q <= dma_bank;
         dma_lsb_q <= dmaa[0];
      end
   end

   always_comb begin
      rd_word = '0;
      if (dma_seen) begin
         rd_word = rdr[dma_bank_q][dma_lsb_q];
      end
   end

   assign {dmadr_imag, dmadr_real} = rd_word;

   // phase stays legal and the writer never shares the DMA bank
   a_phase_legal : assert property (
      @(posedge clk) disable iff (rst)
      (phase inside {PHASE_0, PHASE_1, PHASE_2}) && (wr_bank != dma_bank)
   );

endmodule

// File: src/fft_buf_top.sv
//////////////////////////////
// FFT frame store
// input capture, frame scale and
// triple-buffered DMA readout
//////////////////////////////

module fft_buf_top
   import buf_ctrl_pkg::*, sample_pkg::*;
#(
   parameter int FRAME_LEN = 16,
   parameter int DW = 16,
   localparam int AW = $clog2(FRAME_LEN)
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 run,
   input  logic                 sact_istream,
   input  logic signed [DW-1:0] sdw_istream_real,
   input  logic signed [DW-1:0] sdw_istream_imag,
   input  logic                 dmaact,
   input  logic [AW-1:0]        dmaa,
   output logic signed [DW-1:0] dmadr_real,
   output logic signed [DW-1:0] dmadr_imag,
   output ibuf_state_t          input_buffer_status,
   output sample_bw_t           frame_bw
);

   logic wr_act;
   logic [AW-1:0] wr_addr;

   istream_writer #(
      .FRAME_LEN (FRAME_LEN)
   ) u_writer (
      .clk                 (clk),
      .rst                 (rst),
      .run                 (run),
      .sact_istream        (sact_istream),
      .wr_act              (wr_act),
      .wr_addr             (wr_addr),
      .input_buffer_status (input_buffer_status)
   );

   bfp_frame_scale #(
      .DW (DW)
   ) u_scale (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .sample_act  (wr_act),
      .sample_real (sdw_istream_real),
      .sample_imag (sdw_istream_imag),
      .frame_bw    (frame_bw)
   );

   tribuf_arbiter #(
      .FRAME_LEN (FRAME_LEN),
      .DW        (DW)
   ) u_arbiter (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .wr_act     (wr_act),
      .wr_addr    (wr_addr),
      .wr_real    (sdw_istream_real),
      .wr_imag    (sdw_istream_imag),
      .dmaact     (dmaact),
      .dmaa       (dmaa),
      .dmadr_real (dmadr_real),
      .dmadr_imag (dmadr_imag)
   );

endmodule

// File: tb/fft_buf_tb.sv
//////////////////////////////
// testbench for the FFT frame store
// captures frames, rotates the banks and
// reads every frame back over DMA
//////////////////////////////

module fft_buf_tb
   import buf_ctrl_pkg::*, sample_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int FRAME_LEN = 16;
   localparam int DW = 16;
   localparam int AW = $clog2(FRAME_LEN);
   localparam int N_FRAMES = 8;
   localparam int RESTART_FRAME = 5;
   // about 60 cycles per frame plus reset
   localparam int CYCLE_LIMIT = 4 * (N_FRAMES * 60 + 16);

   logic clk = 1'b0;
   logic rst;
   logic run;
   logic sact_istream;
   logic [DW-1:0] sdw_istream_real;
   logic [DW-1:0] sdw_istream_imag;
   logic dmaact;
   logic [AW-1:0] dmaa;
   logic [DW-1:0] dmadr_real;
   logic [DW-1:0] dmadr_imag;
   ibuf_state_t input_buffer_status;
   sample_bw_t frame_bw;

   logic [15:0] lfsr_state = 16'd19;
   logic [2*DW-1:0] frames [3][FRAME_LEN];
   logic [2*DW-1:0] exp_q [$];
   logic [2*DW-1:0] last_rd_word = '0;
   logic rd_any = 1'b0;
   int model_phase = 0;
   int exp_bw = 1;
   int errors = 0;
   int checks = 0;
   int cycle_count = 0;
   logic rd_seen = 1'b0;

   fft_buf_top #(
      .FRAME_LEN (FRAME_LEN),
      .DW        (DW)
   ) u_dut (
      .clk                 (clk),
      .rst                 (rst),
      .run                 (run),
      .sact_istream        (sact_istream),
      .sdw_istream_real    (sdw_istream_real),
      .sdw_istream_imag    (sdw_istream_imag),
      .dmaact              (dmaact),
      .dmaa                (dmaa),
      .dmadr_real          (dmadr_real),
      .dmadr_imag          (dmadr_imag),
      .input_buffer_status (input_buffer_status),
      .frame_bw            (frame_bw)
   );

   always #20 clk = ~clk;

   //////////////////////////////
   // random source and reference
   //////////////////////////////
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   // random value that fits in mw bits, sign extended
   function automatic logic [DW-1:0] make_sample(input int mw);
      logic [31:0] r;
      r = take_bits(mw);
      for (int i = mw; i < DW; i++) begin
         r[i] = r[mw-1];
      end
      return r[DW-1:0];
   endfunction

   function automatic logic [AW-1:0] bit_reverse(input logic [AW-1:0] a);
      logic [AW-1:0] r;
      for (int i = 0; i < AW; i++) begin
         r[i] = a[AW-1-i];
      end
      return r;
   endfunction

   // smallest n with -2^(n-1) <= v < 2^(n-1)
   function automatic int sample_width(input logic [DW-1:0] v);
      int sv;
      int n;
      sv = $signed(v);
      for (n = 1; n < DW; n++) begin
         if (sv >= -(1 << (n - 1)) && sv < (1 << (n - 1))) begin
            return n;
         end
      end
      return DW;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   //////////////////////////////
   // stimulus tasks
   //////////////////////////////
   task automatic capture_frame(input int n_samples, input int mw);
      logic [DW-1:0] sr;
      logic [DW-1:0] si;
      int k;
      int w;
      k = 0;
      while (k < n_samples) begin
         @(posedge clk);
         if (take_bits(2) == 3) begin
            sact_istream <= 1'b0;
         end else begin
            sr = make_sample(mw);
            si = make_sample(mw);
            sact_istream <= 1'b1;
            sdw_istream_real <= sr;
            sdw_istream_imag <= si;
            frames[model_phase][k] = {si, sr};
            w = (sample_width(sr) > sample_width(si)) ? sample_width(sr) : sample_width(si);
            if (w > exp_bw) begin
               exp_bw = w;
            end
            k++;
         end
      end
      @(posedge clk);
      sact_istream <= 1'b0;
      @(negedge clk);
      check("input_buffer_status", (n_samples == FRAME_LEN) ? IBUF_FULL : IBUF_STREAM,
            input_buffer_status);
   endtask

   // buffer is full, these must not land anywhere
   task automatic ignored_samples(input int n);
      repeat (n) begin
         @(posedge clk);
         sact_istream <= 1'b1;
         sdw_istream_real <= DW'(take_bits(DW));
         sdw_istream_imag <= DW'(take_bits(DW));
      end
      @(posedge clk);
      sact_istream <= 1'b0;
   endtask

   task automatic pulse_run();
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      check("input_buffer_status", IBUF_STREAM, input_buffer_status);
      check("frame_bw", exp_bw, frame_bw);
      // last DMA word stays put across writes and the rotation
      if (rd_any) begin
         check("dmadr_real", last_rd_word[DW-1:0], dmadr_real);
         check("dmadr_imag", last_rd_word[2*DW-1:DW], dmadr_imag);
      end
      model_phase = (model_phase + 1) % 3;
      exp_bw = 1;
   endtask

   // all addresses of the DMA bank in shuffled order
   task automatic dma_readout();
      int order [FRAME_LEN];
      int j;
      int t;
      for (int i = 0; i < FRAME_LEN; i++) begin
         order[i] = i;
      end
      for (int i = FRAME_LEN - 1; i > 0; i--) begin
         j = int'(take_bits(AW)) % (i + 1);
         t = order[i];
         order[i] = order[j];
         order[j] = t;
      end
      for (int i = 0; i < FRAME_LEN; i++) begin
         @(posedge clk);
         dmaact <= 1'b1;
         dmaa <= AW'(order[i]);
         exp_q.push_back(frames[(model_phase + 1) % 3][bit_reverse(AW'(order[i]))]);
      end
      @(posedge clk);
      dmaact <= 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   //////////////////////////////
   // DMA data checker
   //////////////////////////////
   always @(posedge clk) begin
      rd_seen <= dmaact && !rst;
   end

   always @(negedge clk) begin
      logic [2*DW-1:0] exp_word;
      if (rd_seen) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("DMA read data came back with no read outstanding at %0t ns", $time);
         end else begin
            exp_word = exp_q.pop_front();
            check("dmadr_real", exp_word[DW-1:0], dmadr_real);
            check("dmadr_imag", exp_word[2*DW-1:DW], dmadr_imag);
            last_rd_word = exp_word;
            rd_any = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the sequence never completed", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   initial begin
      rst = 1'b1;
      run = 1'b0;
      sact_istream = 1'b0;
      sdw_istream_real = '0;
      sdw_istream_imag = '0;
      dmaact = 1'b0;
      dmaa = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check("input_buffer_status", IBUF_IDLE, input_buffer_status);
      check("frame_bw", 1, frame_bw);
      check("dmadr_real", 0, dmadr_real);
      check("dmadr_imag", 0, dmadr_imag);
      @(negedge clk);
      check("input_buffer_status", IBUF_STREAM, input_buffer_status);
      for (int it = 0; it < N_FRAMES; it++) begin
         if (it == RESTART_FRAME) begin
            capture_frame(5, DW);
         end else begin
            capture_frame(FRAME_LEN, (it % 2 == 1) ? 3 + it : DW);
            ignored_samples(3);
         end
         pulse_run();
         // frame from two runs ago sits on the DMA bank
         if (it >= 1) begin
            dma_readout();
         end
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: src.f
src/buf_ctrl_pkg.sv
src/sample_pkg.sv
src/sample_bank.sv
src/istream_writer.sv
src/bfp_frame_scale.sv
src/tribuf_arbiter.sv
src/fft_buf_top.sv
tb/fft_buf_tb.sv
